// ==== verilog/lg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator shared definitions
// pin width, register map, AXI4-Lite channel structs, control word views
////////////////////////////////////////////////////////////////////////////

package lg_pkg;

  localparam int unsigned lg_dw = 8;  // pins per channel

  typedef logic [lg_dw-1:0] lg_sample_t;  // one table entry

  // pin values with their output enables
  typedef struct packed {
    lg_sample_t o;  // value
    lg_sample_t e;  // enable
  } lg_pin_t;

  //////////////////////////////////////////////////////////////////////////
  // AXI4-Lite channels
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        awvalid;
    logic [11:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [11:0] araddr;
    logic        rready;
  } lg_axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } lg_axil_rsp_t;

  //////////////////////////////////////////////////////////////////////////
  // control word, command on write and status on read
  //////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [27:0] rsv;
    logic        rst;  // clear done and counters
    logic        swt;  // software trigger
    logic        stp;  // stop
    logic        str;  // arm
  } lg_cmd_t;

  typedef struct packed {
    logic [28:0] rsv;
    logic        done;
    logic        run;
    logic        arm;
  } lg_sts_t;

  typedef union packed {
    lg_cmd_t cmd;
    lg_sts_t sts;
  } lg_ctl_u;

  // burst and output configuration
  typedef struct packed {
    logic        inf;  // endless periods
    logic [13:0] bdr;  // repeats per entry minus one
    logic [13:0] bdl;  // entries per period
    logic [31:0] bpl;  // beats per period
    logic [15:0] bpn;  // periods per burst
    lg_sample_t  oe0;  // enable where pin is 0
    lg_sample_t  oe1;  // enable where pin is 1
    lg_sample_t  msk;
    lg_sample_t  val;  // polarity
  } lg_cfg_t;

  // register map
  localparam logic [11:0] lg_off_ctl  = 12'h000;
  localparam logic [11:0] lg_off_trg  = 12'h008;
  localparam logic [11:0] lg_off_mode = 12'h010;
  localparam logic [11:0] lg_off_bdr  = 12'h020;
  localparam logic [11:0] lg_off_bdl  = 12'h024;
  localparam logic [11:0] lg_off_bpl  = 12'h028;
  localparam logic [11:0] lg_off_bpn  = 12'h02c;
  localparam logic [11:0] lg_off_sbpl = 12'h030;
  localparam logic [11:0] lg_off_sbpn = 12'h034;
  localparam logic [11:0] lg_off_oe0  = 12'h040;
  localparam logic [11:0] lg_off_oe1  = 12'h044;
  localparam logic [11:0] lg_off_msk  = 12'h048;
  localparam logic [11:0] lg_off_val  = 12'h04c;
  localparam logic [11:0] lg_off_tbl  = 12'h400;  // table window, word per entry

endpackage

// ==== verilog/lg_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator register block
// AXI4-Lite slave with configuration, trigger mask and table window
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lg_regs import lg_pkg::*; #(
  parameter int unsigned tbl_aw = 8,
  parameter int unsigned tn     = 2
) (
  input  logic                bus,
  input  logic                rst_n,
  input  lg_axil_req_t        axil_req,
  output lg_axil_rsp_t        axil_rsp,
  input  logic [tn-1:0]       trg_ext,
  output lg_cfg_t             cfg,
  output lg_cmd_t             cmd,
  output logic                trg,
  input  lg_sts_t             sts,
  input  logic [31:0]         sts_bpl,
  input  logic [15:0]         sts_bpn,
  output logic                tbl_we,
  output logic                tbl_re,
  output logic [tbl_aw-1:0]   tbl_addr,
  output lg_sample_t          tbl_wdata,
  input  lg_sample_t          tbl_rdata
);

  logic          wr_acc, rd_acc;  // handshakes taken this cycle
  logic          aw_tbl, ar_tbl;  // address hits table window
  logic          bvalid, rvalid;
  logic          rd_tbl;          // table read in flight
  logic [31:0]   rdata;
  logic [31:0]   rd_word;         // register read mux
  logic [tn-1:0] cfg_trg;         // external trigger mask
  lg_ctl_u       ctl_w, ctl_r;

  assign aw_tbl = (axil_req.awaddr[11:10] == lg_off_tbl[11:10]);
  assign ar_tbl = (axil_req.araddr[11:10] == lg_off_tbl[11:10]);

  // write needs both channels, one outstanding response max
  assign wr_acc = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  // table port busy with a write blocks a table read
  assign rd_acc = axil_req.arvalid & ~rvalid & ~rd_tbl & ~(ar_tbl & tbl_we);

  assign axil_rsp.awready = wr_acc;
  assign axil_rsp.wready  = wr_acc;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = 2'b00;  // always OKAY
  assign axil_rsp.arready = rd_acc;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = 2'b00;

  // table port, write wins the shared address
  assign tbl_we    = wr_acc & aw_tbl;
  assign tbl_re    = rd_acc & ar_tbl;
  assign tbl_addr  = tbl_we ? axil_req.awaddr[tbl_aw+1:2] : axil_req.araddr[tbl_aw+1:2];
  assign tbl_wdata = axil_req.wdata[lg_dw-1:0];  // upper bits dropped

  // control word views
  assign ctl_w     = axil_req.wdata;
  assign ctl_r.sts = sts;

  //////////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      bvalid  <= 1'b0;
      cfg     <= '0;
      cfg_trg <= '0;
      cmd     <= '0;
      trg     <= 1'b0;
    end else begin
      if (wr_acc)
        bvalid <= 1'b1;
      else if (axil_req.bready)
        bvalid <= 1'b0;
      // command strobes last one cycle
      cmd <= (wr_acc && axil_req.awaddr == lg_off_ctl) ? ctl_w.cmd : '0;
      trg <= (wr_acc && axil_req.awaddr == lg_off_ctl && ctl_w.cmd.swt)
             | (|(trg_ext & cfg_trg));  // level sensitive
      if (wr_acc) begin
        case (axil_req.awaddr)  // wstrb ignored
          lg_off_trg:  cfg_trg <= axil_req.wdata[tn-1:0];
          lg_off_mode: cfg.inf <= axil_req.wdata[1];
          lg_off_bdr:  cfg.bdr <= axil_req.wdata[13:0];
          lg_off_bdl:  cfg.bdl <= axil_req.wdata[13:0];
          lg_off_bpl:  cfg.bpl <= axil_req.wdata;
          lg_off_bpn:  cfg.bpn <= axil_req.wdata[15:0];
          lg_off_oe0:  cfg.oe0 <= axil_req.wdata[lg_dw-1:0];
          lg_off_oe1:  cfg.oe1 <= axil_req.wdata[lg_dw-1:0];
          lg_off_msk:  cfg.msk <= axil_req.wdata[lg_dw-1:0];
          lg_off_val:  cfg.val <= axil_req.wdata[lg_dw-1:0];
          default: ;  // ctl handled above, rest ignored
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (axil_req.araddr)
      lg_off_ctl:  rd_word = ctl_r;
      lg_off_trg:  rd_word = 32'(cfg_trg);
      lg_off_mode: rd_word = {30'd0, cfg.inf, 1'b0};
      lg_off_bdr:  rd_word = 32'(cfg.bdr);
      lg_off_bdl:  rd_word = 32'(cfg.bdl);
      lg_off_bpl:  rd_word = cfg.bpl;
      lg_off_bpn:  rd_word = 32'(cfg.bpn);
      lg_off_sbpl: rd_word = sts_bpl;
      lg_off_sbpn: rd_word = 32'(sts_bpn);
      lg_off_oe0:  rd_word = 32'(cfg.oe0);
      lg_off_oe1:  rd_word = 32'(cfg.oe1);
      lg_off_msk:  rd_word = 32'(cfg.msk);
      lg_off_val:  rd_word = 32'(cfg.val);
      default:     rd_word = '0;  // unmapped reads zero
    endcase
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
      rd_tbl <= 1'b0;
    end else begin
      rd_tbl <= rd_acc & ar_tbl;
      if ((rd_acc && !ar_tbl) || rd_tbl)
        rvalid <= 1'b1;  // table data one cycle later
      else if (axil_req.rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (rd_tbl)
      rdata <= 32'(tbl_rdata);
    else if (rd_acc && !ar_tbl)
      rdata <= rd_word;
  end

  // responses stay up until the host takes them
  property p_hold(logic v, logic r);
    @(posedge bus) disable iff (!rst_n) v && !r |=> v;
  endproperty

  a_bvalid_hold: assert property (p_hold(bvalid, axil_req.bready));
  a_rvalid_hold: assert property (p_hold(rvalid, axil_req.rready));

endmodule

// ==== verilog/lg_table.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator waveform table
// CPU port synchronous, sequencer port asynchronous read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lg_table import lg_pkg::*; #(
  parameter int unsigned tbl_aw = 8
) (
  input  logic              bus,
  // CPU port
  input  logic              we,
  input  logic              re,
  input  logic [tbl_aw-1:0] addr,
  input  lg_sample_t        wdata,
  output lg_sample_t        rdata,
  // sequencer port
  input  logic [tbl_aw-1:0] seq_addr,
  output lg_sample_t        seq_data
);

  localparam int unsigned depth = 2**tbl_aw;

  lg_sample_t mem [depth];  // contents undefined until loaded

  // CPU access
  always_ff @(posedge bus) begin
    if (we)
      mem[addr] <= wdata;
    if (re)
      rdata <= mem[addr];  // valid the next cycle
  end

  // same-cycle lookup for the sequencer
  assign seq_data = mem[seq_addr];

endmodule

// ==== verilog/lg_burst.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator burst sequencer
// arm/trigger FSM, entry repeat, period padding and period count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lg_burst import lg_pkg::*; #(
  parameter int unsigned tbl_aw = 8
) (
  input  logic              bus,
  input  logic              rst_n,
  input  lg_cfg_t           cfg,
  input  lg_cmd_t           cmd,
  input  logic              trg,
  output lg_sts_t           sts,
  output logic [31:0]       sts_bpl,
  output logic [15:0]       sts_bpn,
  output logic [tbl_aw-1:0] seq_addr,
  input  lg_sample_t        seq_data,
  // stream towards the output stage
  output logic              valid,
  output lg_sample_t        data,
  output logic              last,
  input  logic              ready,
  output logic              per
);

  typedef enum logic [1:0] {st_idle, st_arm, st_run} state_t;

  state_t      state;
  logic [13:0] rep;      // repeat count of current entry
  logic [13:0] ptr;      // table read pointer
  logic [31:0] bpl_cnt;  // beat in period
  logic [15:0] bpn_cnt;  // completed periods
  logic        done;
  logic        xfer, end_per, end_bst, cfg_ok, go;

  assign xfer    = valid & ready;
  assign end_per = (bpl_cnt == cfg.bpl - 32'd1);
  assign end_bst = end_per & ~cfg.inf & (bpn_cnt == cfg.bpn - 16'd1);
  assign cfg_ok  = (cfg.bdl != '0) & (cfg.bpl != '0);  // empty burst never starts
  // arm and trigger may come in the same cycle
  assign go      = trg & cfg_ok & ((state == st_arm) | ((state == st_idle) & cmd.str));

  assign seq_addr = ptr[tbl_aw-1:0];
  assign data     = seq_data;       // held while ptr is held
  assign last     = valid & end_bst;

  assign sts     = '{rsv: '0, done: done, run: (state == st_run), arm: (state == st_arm)};
  assign sts_bpl = bpl_cnt;
  assign sts_bpn = bpn_cnt;

  //////////////////////////////////////////////////////////////////////////
  // sequencer
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state   <= st_idle;
      valid   <= 1'b0;
      rep     <= '0;
      ptr     <= '0;
      bpl_cnt <= '0;
      bpn_cnt <= '0;
      done    <= 1'b0;
      per     <= 1'b0;
    end else begin
      per <= xfer & (bpl_cnt == '0);  // first beat of a period
      if (cmd.stp) begin
        state <= st_idle;  // abort, beat dropped
        valid <= 1'b0;
        done  <= 1'b0;
      end else if (go) begin
        state   <= st_run;
        valid   <= 1'b1;
        done    <= 1'b0;
        rep     <= '0;
        ptr     <= '0;
        bpl_cnt <= '0;
        bpn_cnt <= '0;
      end else if (xfer) begin
        if (end_bst) begin
          state <= st_idle;
          valid <= 1'b0;
          done  <= 1'b1;
        end
        if (end_per) begin
          bpl_cnt <= '0;
          bpn_cnt <= bpn_cnt + 16'd1;
          rep     <= '0;
          ptr     <= '0;
        end else begin
          bpl_cnt <= bpl_cnt + 32'd1;
          if (rep == cfg.bdr) begin
            rep <= '0;
            if (ptr != cfg.bdl - 14'd1)
              ptr <= ptr + 14'd1;  // clamp on last entry, padding
          end else begin
            rep <= rep + 14'd1;
          end
        end
      end else if (cmd.str && state == st_idle) begin
        state <= st_arm;
      end
      // status clear overrides counting
      if (cmd.rst) begin
        done    <= 1'b0;
        bpl_cnt <= '0;
        bpn_cnt <= '0;
      end
    end
  end

  a_ptr_clamp: assert property (@(posedge bus) disable iff (!rst_n)
    state == st_run |-> ptr <= cfg.bdl - 14'd1);

  // stalled beat stays put until the output stage takes it
  a_valid_hold: assert property (@(posedge bus) disable iff (!rst_n)
    valid && !ready && !cmd.stp |=> valid && $stable(ptr));

endmodule

// ==== verilog/lg_drive.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator output stage
// one register slice, sample to pin values and output enables
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lg_drive import lg_pkg::*; (
  input  logic       bus,
  input  logic       rst_n,
  input  lg_cfg_t    cfg,
  input  logic       in_valid,
  input  lg_sample_t in_data,
  input  logic       in_last,
  output logic       in_ready,
  output logic       out_valid,
  output lg_pin_t    pin,
  output logic       out_last,
  input  logic       out_ready
);

  lg_sample_t o;  // shaped pin values

  assign o        = cfg.val ^ (in_data & ~cfg.msk);
  assign in_ready = out_ready | ~out_valid;  // empty slot accepts

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
      out_last  <= in_valid & in_last;
    end
  end

  // pin word, no reset
  always_ff @(posedge bus) begin
    if (in_ready && in_valid) begin
      pin.o <= o;
      pin.e <= (cfg.oe0 & ~o) | (cfg.oe1 & o);  // enable picked by level
    end
  end

endmodule

// ==== verilog/lg_top.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator channel
// register block, waveform table, burst sequencer and output stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lg_top import lg_pkg::*; #(
  parameter int unsigned tbl_aw = 8,
  parameter int unsigned tn     = 2
) (
  input  logic          bus,
  input  logic          rst_n,
  input  lg_axil_req_t  axil_req,
  output lg_axil_rsp_t  axil_rsp,
  input  logic [tn-1:0] trg_ext,
  // pattern stream
  output logic          valid,
  output lg_pin_t       pin,
  output logic          last,
  input  logic          ready,
  // events
  output logic          per,
  output logic          lst,
  output logic          irq
);

  lg_cfg_t           cfg;
  lg_cmd_t           cmd;
  lg_sts_t           sts;
  logic              trg;
  logic [31:0]       sts_bpl;
  logic [15:0]       sts_bpn;
  logic              tbl_we, tbl_re;
  logic [tbl_aw-1:0] tbl_addr, seq_addr;
  lg_sample_t        tbl_wdata, tbl_rdata, seq_data;
  // sequencer to output stage
  logic              s_valid, s_last, s_ready;
  lg_sample_t        s_data;

  lg_regs #(.tbl_aw(tbl_aw), .tn(tn)) u_regs (
    .bus, .rst_n, .axil_req, .axil_rsp, .trg_ext,
    .cfg, .cmd, .trg, .sts, .sts_bpl, .sts_bpn,
    .tbl_we, .tbl_re, .tbl_addr, .tbl_wdata, .tbl_rdata
  );

  lg_table #(.tbl_aw(tbl_aw)) u_table (
    .bus, .we(tbl_we), .re(tbl_re), .addr(tbl_addr),
    .wdata(tbl_wdata), .rdata(tbl_rdata), .seq_addr, .seq_data
  );

  lg_burst #(.tbl_aw(tbl_aw)) u_burst (
    .bus, .rst_n, .cfg, .cmd, .trg, .sts, .sts_bpl, .sts_bpn,
    .seq_addr, .seq_data, .valid(s_valid), .data(s_data),
    .last(s_last), .ready(s_ready), .per
  );

  lg_drive u_drive (
    .bus, .rst_n, .cfg, .in_valid(s_valid), .in_data(s_data),
    .in_last(s_last), .in_ready(s_ready), .out_valid(valid),
    .pin, .out_last(last), .out_ready(ready)
  );

  // end of burst seen at the pins, then interrupt
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      lst <= 1'b0;
      irq <= 1'b0;
    end else begin
      lst <= valid & ready & last;
      irq <= lst;
    end
  end

endmodule

// ==== tb/lg_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// logic generator channel testbench
// AXI4-Lite driver, LFSR stimulus, burst and pin reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lg_tb import lg_pkg::*;;

  // one test case, fields in table order
  typedef struct packed {
    logic        inf;
    logic [13:0] bdr;
    logic [13:0] bdl;
    logic [31:0] bpl;
    logic [15:0] bpn;
    lg_sample_t  msk;
    lg_sample_t  val;
    lg_sample_t  oe0;
    lg_sample_t  oe1;
    logic [1:0]  src;  // 0 software, 1 ext0, 2 ext1
    logic        bp;   // random ready
  } row_t;

  localparam int n_rows = 6;
  localparam int n_tbl  = 32;  // entries loaded

  // configuration registers with their implemented bits
  localparam logic [11:0] reg_off [10] = '{lg_off_trg, lg_off_mode, lg_off_bdr,
    lg_off_bdl, lg_off_bpl, lg_off_bpn, lg_off_oe0, lg_off_oe1, lg_off_msk, lg_off_val};
  localparam logic [31:0] reg_msk [10] = '{32'h3, 32'h2, 32'h3fff, 32'h3fff,
    32'hffff_ffff, 32'hffff, 32'hff, 32'hff, 32'hff, 32'hff};

  logic         bus, rst_n;
  lg_axil_req_t axil_req;
  lg_axil_rsp_t axil_rsp;
  logic [1:0]   trg_ext;
  logic         valid, last, ready, per, lst, irq;
  lg_pin_t      pin;

  logic [31:0]  lfsr_q;
  logic         bp_en;             // ready from LFSR when set
  lg_sample_t   tbl_exp [n_tbl];   // table shadow
  row_t         rows [n_rows];
  lg_pin_t      got_pin [$];       // beats seen at the pins
  logic         got_last [$];
  int           n_per, n_lst, n_irq;

  lg_top #(.tbl_aw(8), .tn(2)) uut (
    .bus, .rst_n, .axil_req, .axil_rsp, .trg_ext,
    .valid, .pin, .last, .ready, .per, .lst, .irq
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  // x^32+x^22+x^2+x+1, one bit per step
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  task automatic axil_write(input logic [11:0] addr, input logic [31:0] data);
    int n;
    n = 0;
    @(posedge bus);
    #1;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hf;
    axil_req.bready  = 1'b1;
    do begin
      @(negedge bus);
      if (++n > 50) abort_run("write address and data accept");
    end while (!axil_rsp.awready);
    check("wready", axil_rsp.wready, 1'b1);  // both channels taken together
    @(posedge bus);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    do begin
      @(negedge bus);
      if (++n > 50) abort_run("write response");
    end while (!axil_rsp.bvalid);
    check("bresp", axil_rsp.bresp, 2'b00);  // OKAY
  endtask

  task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge bus);
    #1;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    do begin
      @(negedge bus);
      if (++n > 50) abort_run("read address accept");
    end while (!axil_rsp.arready);
    @(posedge bus);
    #1;
    axil_req.arvalid = 1'b0;
    n = 0;
    do begin
      @(negedge bus);
      if (++n > 50) abort_run("read data");
    end while (!axil_rsp.rvalid);
    check("rresp", axil_rsp.rresp, 2'b00);  // OKAY, unmapped too
    data = axil_rsp.rdata;
  endtask

  task automatic read_check(input string name, input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] d;
    axil_read(addr, d);
    check(name, d, exp);
  endtask

  // expected pin word for beat k of a burst
  function automatic lg_pin_t exp_pin(input row_t r, input int k);
    int      idx;
    lg_pin_t p;
    idx = (k % int'(r.bpl)) / (int'(r.bdr) + 1);
    if (idx > int'(r.bdl) - 1)
      idx = int'(r.bdl) - 1;  // padding repeats last entry
    p.o = r.val ^ (tbl_exp[idx] & ~r.msk);
    p.e = (r.oe0 & ~p.o) | (r.oe1 & p.o);
    return p;
  endfunction

  task automatic load_cfg(input row_t r);
    axil_write(lg_off_mode, {30'd0, r.inf, 1'b0});
    axil_write(lg_off_bdr, 32'(r.bdr));
    axil_write(lg_off_bdl, 32'(r.bdl));
    axil_write(lg_off_bpl, r.bpl);
    axil_write(lg_off_bpn, 32'(r.bpn));
    axil_write(lg_off_oe0, 32'(r.oe0));
    axil_write(lg_off_oe1, 32'(r.oe1));
    axil_write(lg_off_msk, 32'(r.msk));
    axil_write(lg_off_val, 32'(r.val));
    axil_write(lg_off_trg, (r.src == 2'd0) ? 32'd0 : 32'd1 << (r.src - 2'd1));
  endtask

  task automatic fire_trigger(input logic [1:0] src);
    if (src == 2'd0) begin
      axil_write(lg_off_ctl, 32'h4);  // swt
    end else begin
      @(posedge bus);
      #1 trg_ext = 2'b01 << (src - 2'd1);
      @(posedge bus);
      #1 trg_ext = 2'b00;
    end
  endtask

  task automatic clear_monitor();
    got_pin.delete();
    got_last.delete();
    n_per = 0;
    n_lst = 0;
    n_irq = 0;
  endtask

  task automatic wait_beats(input int n);
    int t;
    t = 0;
    while (got_pin.size() < n) begin
      @(posedge bus);
      if (++t > 40 * n + 200) abort_run("burst beats");
    end
  endtask

  task automatic wait_valid_low();
    int t;
    t = 0;
    do begin
      @(negedge bus);
      if (++t > 20) abort_run("valid to drop after stop");
    end while (valid);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one table row: configure, arm, trigger, compare with model
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input int i);
    row_t    r;
    int      total;
    lg_pin_t p;
    r = rows[i];
    total = int'(r.bpl) * int'(r.bpn);
    load_cfg(r);
    axil_write(lg_off_ctl, 32'h8);  // clear done and counters
    clear_monitor();
    bp_en = r.bp;
    axil_write(lg_off_ctl, 32'h1);  // arm
    fire_trigger(r.src);
    if (r.inf) begin
      wait_beats(3 * total);  // well past bpn periods
      axil_write(lg_off_ctl, 32'h2);
      wait_valid_low();
    end else begin
      wait_beats(total);
    end
    repeat (6) @(posedge bus);  // room for irq and stray beats
    bp_en = 1'b0;
    check("valid", valid, 1'b0);
    if (!r.inf)
      check("beat count", got_pin.size(), total);
    for (int k = 0; k < got_pin.size(); k++) begin
      p = exp_pin(r, k);
      check($sformatf("row %0d beat %0d pin.o", i, k), got_pin[k].o, p.o);
      check($sformatf("row %0d beat %0d pin.e", i, k), got_pin[k].e, p.e);
      check($sformatf("row %0d beat %0d last", i, k), got_last[k],
            !r.inf && (k == total - 1));
    end
    if (r.inf) begin
      check("lst count", n_lst, 0);
      check("irq count", n_irq, 0);
      read_check("sts", lg_off_ctl, 32'h0);  // not run, not done
    end else begin
      check("per count", n_per, int'(r.bpn));
      check("lst count", n_lst, 1);
      check("irq count", n_irq, 1);
      read_check("sts", lg_off_ctl, 32'h4);  // done only
      read_check("sbpn", lg_off_sbpn, 32'(r.bpn));
    end
  endtask

  // output ready, random under back-pressure
  always @(posedge bus) begin
    #1 ready = bp_en ? lfsr_bit() : 1'b1;
  end

  // beat and event monitor
  always @(negedge bus) begin
    if (rst_n) begin
      if (valid && ready) begin
        got_pin.push_back(pin);
        got_last.push_back(last);
      end
      if (per) n_per++;
      if (lst) n_lst++;
      if (irq) n_irq++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] w;
    axil_req = '0;
    trg_ext  = 2'b00;
    ready    = 1'b0;
    rst_n    = 1'b0;
    bp_en    = 1'b0;
    lfsr_q   = 32'he72a;
    n_per    = 0;
    n_lst    = 0;
    n_irq    = 0;
    //         inf  bdr    bdl    bpl     bpn    msk    val    oe0    oe1    src   bp
    rows[0] = '{1'b0, 14'd0, 14'd4, 32'd4,  16'd1, 8'h00, 8'h00, 8'hff, 8'hff, 2'd0, 1'b0};
    rows[1] = '{1'b0, 14'd2, 14'd3, 32'd12, 16'd2, 8'h00, 8'h00, 8'h00, 8'hff, 2'd0, 1'b0};
    rows[2] = '{1'b0, 14'd1, 14'd5, 32'd7,  16'd3, 8'h0f, 8'ha5, 8'hf0, 8'h0f, 2'd1, 1'b0};
    rows[3] = '{1'b0, 14'd2, 14'd3, 32'd12, 16'd2, 8'h00, 8'h00, 8'h00, 8'hff, 2'd2, 1'b1};
    rows[4] = '{1'b0, 14'd0, 14'd8, 32'd10, 16'd2, 8'h3c, 8'h81, 8'h55, 8'haa, 2'd0, 1'b1};
    rows[5] = '{1'b1, 14'd1, 14'd3, 32'd5,  16'd2, 8'h81, 8'h18, 8'hff, 8'h0f, 2'd0, 1'b0};
    repeat (4) @(posedge bus);
    #1 rst_n = 1'b1;

    // status after reset, unmapped offset
    read_check("sts", lg_off_ctl, 32'h0);
    read_check("sbpl", lg_off_sbpl, 32'h0);
    read_check("sbpn", lg_off_sbpn, 32'h0);
    read_check("unmapped", 12'h0f0, 32'h0);

    // configuration readback with random words
    for (int i = 0; i < 10; i++) begin
      w = lfsr_bits(32);
      axil_write(reg_off[i], w);
      read_check($sformatf("reg %h", reg_off[i]), reg_off[i], w & reg_msk[i]);
    end

    // table load through the window
    for (int i = 0; i < n_tbl; i++) begin
      tbl_exp[i] = lfsr_bits(8);
      axil_write(lg_off_tbl + 12'(4 * i), {24'hffffff, tbl_exp[i]});  // upper bits dropped
    end
    for (int i = 0; i < n_tbl; i++)
      read_check($sformatf("tbl[%0d]", i), lg_off_tbl + 12'(4 * i), 32'(tbl_exp[i]));

    // external trigger needs both mask bit and arm
    load_cfg(rows[0]);  // mask cleared
    clear_monitor();
    axil_write(lg_off_ctl, 32'h1);
    read_check("sts armed", lg_off_ctl, 32'h1);
    @(posedge bus);
    #1 trg_ext = 2'b11;
    repeat (4) @(posedge bus);
    #1 trg_ext = 2'b00;
    repeat (4) @(posedge bus);
    check("beats with trigger masked", got_pin.size(), 0);
    read_check("sts still armed", lg_off_ctl, 32'h1);
    axil_write(lg_off_ctl, 32'h2);  // disarm
    axil_write(lg_off_trg, 32'h3);
    @(posedge bus);
    #1 trg_ext = 2'b11;
    repeat (4) @(posedge bus);
    #1 trg_ext = 2'b00;
    repeat (4) @(posedge bus);
    check("beats while not armed", got_pin.size(), 0);
    read_check("sts idle", lg_off_ctl, 32'h0);

    for (int i = 0; i < n_rows; i++)
      run_row(i);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== lg_top.f ====
verilog/lg_pkg.sv
verilog/lg_regs.sv
verilog/lg_table.sv
verilog/lg_burst.sv
verilog/lg_drive.sv
verilog/lg_top.sv
tb/lg_tb.sv

// ==== Bender.yml ====
package:
  name: lg_top

sources:
  - verilog/lg_pkg.sv
  - verilog/lg_regs.sv
  - verilog/lg_table.sv
  - verilog/lg_burst.sv
  - verilog/lg_drive.sv
  - verilog/lg_top.sv
  - target: test
    files:
      - tb/lg_tb.sv
